/* Makefile */
# Verilator build and run of the tile memory testbench

TOP := tb_tcdm_tile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Test run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
source/tile_cfg_pkg.sv
source/tile_txn_pkg.sv
source/bank_req_if.sv
source/address_decode.sv
source/bank_array.sv
source/resp_order.sv
source/tcdm_tile.sv
tb/tb_tcdm_tile.sv

/* source/address_decode.sv */
// Request register, region and tile decode, remote address swap and issue
`timescale 1ns/10ps
`default_nettype none

module address_decode (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  tile_txn_pkg::tile_id_t tile_id_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  tile_txn_pkg::addr_t    req_addr_i,
  input  logic                   req_wen_i,
  input  tile_txn_pkg::data_t    req_wdata_i,
  input  tile_txn_pkg::strb_t    req_be_i,
  bank_req_if.decoder            bank_o,
  output logic                   issue_valid_o,
  output tile_txn_pkg::route_e   issue_route_o,
  input  logic                   issue_ready_i,
  output logic                   rmt_req_valid_o,
  input  logic                   rmt_req_ready_i,
  output tile_txn_pkg::addr_t    rmt_req_addr_o,
  output logic                   rmt_req_wen_o,
  output tile_txn_pkg::data_t    rmt_req_wdata_o,
  output tile_txn_pkg::strb_t    rmt_req_be_o
);

  // Decode register
  logic                 full_q;
  tile_txn_pkg::addr_t  addr_q;
  logic                 wen_q;
  tile_txn_pkg::data_t  wdata_q;
  tile_txn_pkg::strb_t  be_q;
  // Comes up at the first edge after reset
  logic                 ready_en_q;

  tile_txn_pkg::addr_t  tcdm_off;
  tile_txn_pkg::route_e route;
  logic                 path_ready;
  logic                 drain;
  logic                 accept;

  // Offset into the shared region
  assign tcdm_off = addr_q - tile_cfg_pkg::TcdmBase;

  always_comb begin
    if (tcdm_off >= tile_cfg_pkg::TcdmSize) begin
      route = tile_txn_pkg::ROUTE_ERROR;
    end else if (tcdm_off[tile_cfg_pkg::TileLsb +: tile_cfg_pkg::TileBits] == tile_id_i) begin
      route = tile_txn_pkg::ROUTE_LOCAL;
    end else begin
      route = tile_txn_pkg::ROUTE_REMOTE;
    end
  end

  // Error requests need no path
  always_comb begin
    case (route)
      tile_txn_pkg::ROUTE_LOCAL:  path_ready = bank_o.ready;
      tile_txn_pkg::ROUTE_REMOTE: path_ready = rmt_req_ready_i;
      default:                    path_ready = 1'b1;
    endcase
  end

  assign drain       = full_q && issue_ready_i && path_ready;
  assign req_ready_o = ready_en_q && (!full_q || drain);
  assign accept      = req_valid_i && req_ready_o;

  assign issue_valid_o = full_q && path_ready;
  assign issue_route_o = route;

  // Local path
  assign bank_o.valid    = full_q && issue_ready_i && (route == tile_txn_pkg::ROUTE_LOCAL);
  assign bank_o.wen      = wen_q;
  assign bank_o.row      = tcdm_off[tile_cfg_pkg::RowLsb +: tile_cfg_pkg::RowWidth];
  assign bank_o.bank_sel = tcdm_off[tile_cfg_pkg::BankLsb +: tile_cfg_pkg::BankBits];
  assign bank_o.wdata    = wdata_q;
  assign bank_o.be       = be_q;

  // Remote path, bank and tile fields swapped for the cluster interconnect
  assign rmt_req_valid_o = full_q && issue_ready_i && (route == tile_txn_pkg::ROUTE_REMOTE);
  assign rmt_req_addr_o  = {addr_q[tile_cfg_pkg::AddrWidth-1:tile_cfg_pkg::RowLsb],
                            addr_q[tile_cfg_pkg::BankLsb +: tile_cfg_pkg::BankBits],
                            addr_q[tile_cfg_pkg::TileLsb +: tile_cfg_pkg::TileBits],
                            addr_q[tile_cfg_pkg::ByteOffset-1:0]};
  assign rmt_req_wen_o   = wen_q;
  assign rmt_req_wdata_o = wdata_q;
  assign rmt_req_be_o    = be_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q     <= 1'b0;
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
      if (accept) begin
        full_q <= 1'b1;
      end else if (drain) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= req_addr_i;
      wen_q   <= req_wen_i;
      wdata_q <= req_wdata_i;
      be_q    <= req_be_i;
    end
  end

  // A waiting request keeps its path valid and its contents until taken
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (bank_o.valid && !bank_o.ready) || (rmt_req_valid_o && !rmt_req_ready_i) |=>
      (bank_o.valid || rmt_req_valid_o) && $stable(addr_q) && $stable(wen_q) &&
      $stable(wdata_q) && $stable(be_q))
    else $error("Decode register changed while its request was waiting");

endmodule

`default_nettype wire

/* source/bank_array.sv */
// Two byte-enabled SRAM banks with an access stage and a response hold register
`timescale 1ns/10ps
`default_nettype none

module bank_array (
  input  logic                clk_i,
  input  logic                arst_n_i,
  bank_req_if.bank            bank_i,
  output logic                bank_resp_valid_o,
  input  logic                bank_resp_ready_i,
  output tile_txn_pkg::data_t bank_resp_rdata_o
);

  // One memory per bank, selected by the bank field
  tile_txn_pkg::data_t mem_q [tile_cfg_pkg::BanksPerTile][2 ** tile_cfg_pkg::RowWidth];

  // Access stage
  logic                acc_valid_q;
  logic                acc_wen_q;
  tile_txn_pkg::data_t mem_rdata_q;

  // Hold register
  logic                resp_valid_q;
  tile_txn_pkg::data_t resp_rdata_q;

  logic                hold_free;
  logic                access;

  assign hold_free    = !resp_valid_q || bank_resp_ready_i;
  assign bank_i.ready = hold_free;
  assign access       = bank_i.valid && hold_free;

  assign bank_resp_valid_o = resp_valid_q;
  assign bank_resp_rdata_o = resp_rdata_q;

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (bank_i.wen) begin
        // Only the enabled bytes change
        for (int i = 0; i < tile_cfg_pkg::BeWidth; i++) begin
          if (bank_i.be[i]) begin
            mem_q[bank_i.bank_sel][bank_i.row][8*i +: 8] <= bank_i.wdata[8*i +: 8];
          end
        end
      end else begin
        mem_rdata_q <= mem_q[bank_i.bank_sel][bank_i.row];
      end
      acc_wen_q <= bank_i.wen;
    end
    // Writes answer with zero data
    if (acc_valid_q && hold_free) begin
      resp_rdata_q <= acc_wen_q ? '0 : mem_rdata_q;
    end
  end

  // Both stages advance together whenever the hold register frees up
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_valid_q  <= 1'b0;
      resp_valid_q <= 1'b0;
    end else if (hold_free) begin
      acc_valid_q  <= access;
      resp_valid_q <= acc_valid_q;
    end
  end

  // A stalled access and its held response both survive the stall
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    acc_valid_q && !hold_free |=>
      acc_valid_q && resp_valid_q && $stable(mem_rdata_q) && $stable(resp_rdata_q))
    else $error("Bank response lost while the hold register was refused");

endmodule

`default_nettype wire

/* source/bank_req_if.sv */
// Interface carrying a decoded local request from the decoder to the banks
`timescale 1ns/10ps
`default_nettype none

interface bank_req_if;

  // Handshake
  logic                    valid;
  logic                    ready;

  // Payload, stable while valid waits for ready
  logic                    wen;
  tile_txn_pkg::row_t      row;
  tile_txn_pkg::bank_sel_t bank_sel;
  tile_txn_pkg::data_t     wdata;
  tile_txn_pkg::strb_t     be;

  modport decoder (
    output valid, wen, row, bank_sel, wdata, be,
    input  ready
  );

  modport bank (
    input  valid, wen, row, bank_sel, wdata, be,
    output ready
  );

endinterface

`default_nettype wire

/* source/resp_order.sv */
// In-order route queue and response selection, with immediate error responses
`timescale 1ns/10ps
`default_nettype none

module resp_order (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 issue_valid_i,
  input  tile_txn_pkg::route_e issue_route_i,
  output logic                 issue_ready_o,
  input  logic                 bank_resp_valid_i,
  output logic                 bank_resp_ready_o,
  input  tile_txn_pkg::data_t  bank_resp_rdata_i,
  input  logic                 rmt_resp_valid_i,
  output logic                 rmt_resp_ready_o,
  input  tile_txn_pkg::data_t  rmt_resp_rdata_i,
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output tile_txn_pkg::data_t  resp_rdata_o,
  output logic                 resp_error_o
);

  // Route queue in issue order
  tile_txn_pkg::route_e                     route_q [tile_cfg_pkg::QueueDepth];
  logic [tile_cfg_pkg::QueuePtrWidth-1:0]   wr_ptr_q;
  logic [tile_cfg_pkg::QueuePtrWidth-1:0]   rd_ptr_q;
  logic [tile_cfg_pkg::QueueCntWidth-1:0]   count_q;
  // Remote entries currently queued
  logic [tile_cfg_pkg::QueueCntWidth-1:0]   rmt_cnt_q;

  tile_txn_pkg::route_e head;
  logic                 head_valid;
  logic                 push;
  logic                 pop;

  assign head_valid    = count_q != '0;
  assign head          = route_q[rd_ptr_q];
  assign issue_ready_o = count_q < tile_cfg_pkg::QueueDepth;
  assign push          = issue_valid_i && issue_ready_o;
  assign pop           = resp_valid_o && resp_ready_i;

  // Only the path named by the head sees ready
  always_comb begin
    resp_valid_o      = 1'b0;
    resp_rdata_o      = '0;
    resp_error_o      = 1'b0;
    bank_resp_ready_o = 1'b0;
    rmt_resp_ready_o  = 1'b0;
    if (head_valid) begin
      case (head)
        tile_txn_pkg::ROUTE_LOCAL: begin
          resp_valid_o      = bank_resp_valid_i;
          resp_rdata_o      = bank_resp_rdata_i;
          bank_resp_ready_o = resp_ready_i;
        end
        tile_txn_pkg::ROUTE_REMOTE: begin
          resp_valid_o     = rmt_resp_valid_i;
          resp_rdata_o     = rmt_resp_rdata_i;
          rmt_resp_ready_o = resp_ready_i;
        end
        default: begin
          resp_valid_o = 1'b1;
          resp_error_o = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      route_q[wr_ptr_q] <= issue_route_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      rmt_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
      if (push && issue_route_i == tile_txn_pkg::ROUTE_REMOTE) begin
        if (!(pop && head == tile_txn_pkg::ROUTE_REMOTE)) begin
          rmt_cnt_q <= rmt_cnt_q + 1'b1;
        end
      end else if (pop && head == tile_txn_pkg::ROUTE_REMOTE) begin
        rmt_cnt_q <= rmt_cnt_q - 1'b1;
      end
    end
  end

  // The remote side only answers requests it was sent
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rmt_resp_valid_i |-> rmt_cnt_q != '0)
    else $error("Remote response arrived with no remote request outstanding");

endmodule

`default_nettype wire

/* source/tcdm_tile.sv */
// Tile memory top level connecting the decoder, the banks and the response queue
`timescale 1ns/10ps
`default_nettype none

module tcdm_tile (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  tile_txn_pkg::tile_id_t tile_id_i,
  // Core request
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  tile_txn_pkg::addr_t    req_addr_i,
  input  logic                   req_wen_i,
  input  tile_txn_pkg::data_t    req_wdata_i,
  input  tile_txn_pkg::strb_t    req_be_i,
  // Core response
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i,
  output tile_txn_pkg::data_t    resp_rdata_o,
  output logic                   resp_error_o,
  // Remote request
  output logic                   rmt_req_valid_o,
  input  logic                   rmt_req_ready_i,
  output tile_txn_pkg::addr_t    rmt_req_addr_o,
  output logic                   rmt_req_wen_o,
  output tile_txn_pkg::data_t    rmt_req_wdata_o,
  output tile_txn_pkg::strb_t    rmt_req_be_o,
  // Remote response
  input  logic                   rmt_resp_valid_i,
  output logic                   rmt_resp_ready_o,
  input  tile_txn_pkg::data_t    rmt_resp_rdata_i
);

  // Issue channel
  logic                 issue_valid;
  tile_txn_pkg::route_e issue_route;
  logic                 issue_ready;

  // Local response
  logic                 bank_resp_valid;
  logic                 bank_resp_ready;
  tile_txn_pkg::data_t  bank_resp_rdata;

  bank_req_if bank_req ();

  address_decode i_address_decode (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .tile_id_i       (tile_id_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_addr_i      (req_addr_i),
    .req_wen_i       (req_wen_i),
    .req_wdata_i     (req_wdata_i),
    .req_be_i        (req_be_i),
    .bank_o          (bank_req.decoder),
    .issue_valid_o   (issue_valid),
    .issue_route_o   (issue_route),
    .issue_ready_i   (issue_ready),
    .rmt_req_valid_o (rmt_req_valid_o),
    .rmt_req_ready_i (rmt_req_ready_i),
    .rmt_req_addr_o  (rmt_req_addr_o),
    .rmt_req_wen_o   (rmt_req_wen_o),
    .rmt_req_wdata_o (rmt_req_wdata_o),
    .rmt_req_be_o    (rmt_req_be_o)
  );

  bank_array i_bank_array (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .bank_i            (bank_req.bank),
    .bank_resp_valid_o (bank_resp_valid),
    .bank_resp_ready_i (bank_resp_ready),
    .bank_resp_rdata_o (bank_resp_rdata)
  );

  resp_order i_resp_order (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .issue_valid_i     (issue_valid),
    .issue_route_i     (issue_route),
    .issue_ready_o     (issue_ready),
    .bank_resp_valid_i (bank_resp_valid),
    .bank_resp_ready_o (bank_resp_ready),
    .bank_resp_rdata_i (bank_resp_rdata),
    .rmt_resp_valid_i  (rmt_resp_valid_i),
    .rmt_resp_ready_o  (rmt_resp_ready_o),
    .rmt_resp_rdata_i  (rmt_resp_rdata_i),
    .resp_valid_o      (resp_valid_o),
    .resp_ready_i      (resp_ready_i),
    .resp_rdata_o      (resp_rdata_o),
    .resp_error_o      (resp_error_o)
  );

endmodule

`default_nettype wire

/* source/tile_cfg_pkg.sv */
// Address map constants, field positions and widths of the shared tile memory
`default_nettype none

package tile_cfg_pkg;

  // Data path
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;
  localparam int unsigned AddrWidth = 32;

  // Cluster geometry
  localparam int unsigned NumTiles     = 4;
  localparam int unsigned BanksPerTile = 2;
  localparam int unsigned RowWidth     = 8;

  // Word interleaving, low to high: byte offset, bank, tile, row
  localparam int unsigned ByteOffset = 2;
  localparam int unsigned BankBits   = 1;
  localparam int unsigned TileBits   = 2;
  localparam int unsigned BankLsb    = ByteOffset;
  localparam int unsigned TileLsb    = BankLsb + BankBits;
  localparam int unsigned RowLsb     = TileLsb + TileBits;

  // Shared region, 8 KiB over all tiles
  localparam int unsigned TcdmBase = 32'h0000_0000;
  localparam int unsigned TcdmSize = NumTiles * BanksPerTile * (2 ** RowWidth) * BeWidth;

  // Responses that may be outstanding at once
  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned QueuePtrWidth = $clog2(QueueDepth);
  localparam int unsigned QueueCntWidth = $clog2(QueueDepth + 1);

endpackage

`default_nettype wire

/* source/tile_txn_pkg.sv */
// Transaction field types and the route enum of the tile memory
`default_nettype none

package tile_txn_pkg;

  // Request fields
  typedef logic [tile_cfg_pkg::AddrWidth-1:0] addr_t;
  typedef logic [tile_cfg_pkg::DataWidth-1:0] data_t;
  typedef logic [tile_cfg_pkg::BeWidth-1:0]   strb_t;

  // Decoded address fields
  typedef logic [tile_cfg_pkg::RowWidth-1:0]  row_t;
  typedef logic [tile_cfg_pkg::BankBits-1:0]  bank_sel_t;
  typedef logic [tile_cfg_pkg::TileBits-1:0]  tile_id_t;

  // Where a request is served
  typedef enum logic [1:0] {
    ROUTE_LOCAL  = 2'd0,
    ROUTE_REMOTE = 2'd1,
    ROUTE_ERROR  = 2'd2
  } route_e;

endpackage

`default_nettype wire

/* tb/tb_tcdm_tile.sv */
// Testbench for the tile memory with a remote-side model, directed tests and a checker
`timescale 1ns/10ps
`default_nettype none

module tb_tcdm_tile;

  localparam int          TimeoutCycles = 300;
  localparam logic [1:0]  TileId        = 2'd2;
  localparam logic [31:0] RmtXor        = 32'h5a5a_0000;

  logic        clk_i = 1'b0;
  logic        arst_n_i;
  logic        req_valid_i;
  logic        req_ready_o;
  logic [31:0] req_addr_i;
  logic        req_wen_i;
  logic [31:0] req_wdata_i;
  logic [3:0]  req_be_i;
  logic        resp_valid_o;
  logic        resp_ready_i;
  logic [31:0] resp_rdata_o;
  logic        resp_error_o;
  logic        rmt_req_valid_o;
  logic        rmt_req_ready_i;
  logic [31:0] rmt_req_addr_o;
  logic        rmt_req_wen_o;
  logic [31:0] rmt_req_wdata_o;
  logic [3:0]  rmt_req_be_o;
  logic        rmt_resp_valid_i;
  logic        rmt_resp_ready_o;
  logic [31:0] rmt_resp_rdata_i;

  // Expected core responses in issue order
  logic [31:0] exp_rdata [$];
  logic        exp_error [$];
  // Expected remote requests, and those the remote side has taken
  logic [31:0] exp_rmt_addr [$];
  logic        exp_rmt_wen [$];
  logic [31:0] exp_rmt_wdata [$];
  logic [3:0]  exp_rmt_be [$];
  logic [31:0] rmt_pending [$];
  // Local words keyed by {row, bank}
  logic [31:0] model_mem [int unsigned];
  int          error_count;
  int          rmt_extra_delay;

  always #10 clk_i = ~clk_i;

  tcdm_tile UUT (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .tile_id_i        (TileId),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .req_addr_i       (req_addr_i),
    .req_wen_i        (req_wen_i),
    .req_wdata_i      (req_wdata_i),
    .req_be_i         (req_be_i),
    .resp_valid_o     (resp_valid_o),
    .resp_ready_i     (resp_ready_i),
    .resp_rdata_o     (resp_rdata_o),
    .resp_error_o     (resp_error_o),
    .rmt_req_valid_o  (rmt_req_valid_o),
    .rmt_req_ready_i  (rmt_req_ready_i),
    .rmt_req_addr_o   (rmt_req_addr_o),
    .rmt_req_wen_o    (rmt_req_wen_o),
    .rmt_req_wdata_o  (rmt_req_wdata_o),
    .rmt_req_be_o     (rmt_req_be_o),
    .rmt_resp_valid_i (rmt_resp_valid_i),
    .rmt_resp_ready_o (rmt_resp_ready_o),
    .rmt_resp_rdata_i (rmt_resp_rdata_i)
  );

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      error_count++;
      $display("** Error at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout after %0d cycles waiting for %s", TimeoutCycles, what);
    abort_run();
  endtask

  // Bank and tile fields trade places on the way out
  function automatic logic [31:0] swap_fields(input logic [31:0] addr);
    return {addr[31:5], addr[2], addr[4:3], addr[1:0]};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] word;
    word = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        word[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return word;
  endfunction

  // Route by the address map and record what the DUT must answer
  task automatic expect_resp(input logic [31:0] addr, input logic wen,
                             input logic [31:0] wdata, input logic [3:0] be);
    int unsigned key;
    key = {addr[12:5], addr[2]};
    if (addr >= tile_cfg_pkg::TcdmSize) begin
      exp_rdata.push_back(32'h0);
      exp_error.push_back(1'b1);
    end else if (addr[4:3] == TileId) begin
      if (wen) begin
        model_mem[key] = merge_bytes(model_mem.exists(key) ? model_mem[key] : 32'h0, wdata, be);
        exp_rdata.push_back(32'h0);
      end else begin
        exp_rdata.push_back(model_mem[key]);
      end
      exp_error.push_back(1'b0);
    end else begin
      exp_rmt_addr.push_back(swap_fields(addr));
      exp_rmt_wen.push_back(wen);
      exp_rmt_wdata.push_back(wdata);
      exp_rmt_be.push_back(be);
      exp_rdata.push_back(swap_fields(addr) ^ RmtXor);
      exp_error.push_back(1'b0);
    end
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic send_req(input logic [31:0] addr, input logic wen,
                          input logic [31:0] wdata, input logic [3:0] be);
    int cycles;
    expect_resp(addr, wen, wdata, be);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_wen_i   = wen;
    req_wdata_i = wdata;
    req_be_i    = be;
    cycles = 0;
    @(negedge clk_i);
    while (!req_ready_o) begin
      cycles++;
      if (cycles > TimeoutCycles) begin
        timeout_abort("the core request handshake");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drained(input string what);
    int cycles;
    cycles = 0;
    while (exp_rdata.size() != 0) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TimeoutCycles) begin
        timeout_abort(what);
      end
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic apply_reset();
    int cycles;
    repeat (16) @(posedge clk_i);
    check_value(req_ready_o, 1'b0, "req_ready_o during reset");
    check_value(resp_valid_o, 1'b0, "resp_valid_o during reset");
    check_value(rmt_req_valid_o, 1'b0, "rmt_req_valid_o during reset");
    check_value(rmt_resp_ready_o, 1'b0, "rmt_resp_ready_o during reset");
    #2;
    arst_n_i = 1'b1;
    cycles = 0;
    @(negedge clk_i);
    while (!req_ready_o) begin
      cycles++;
      if (cycles > TimeoutCycles) begin
        timeout_abort("req_ready_o after reset");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic test_local();
    // Full words first so later partial writes merge into known data
    send_req(32'h0000_0010, 1'b1, 32'h1111_2222, 4'hf);
    send_req(32'h0000_0014, 1'b1, 32'h3333_4444, 4'hf);
    send_req(32'h0000_0030, 1'b1, 32'h5555_6666, 4'hf);
    send_req(32'h0000_1ff4, 1'b1, 32'h7777_8888, 4'hf);
    send_req(32'h0000_0030, 1'b1, 32'hdead_beef, 4'b0101);
    send_req(32'h0000_1ff4, 1'b1, 32'hcafe_f00d, 4'b1000);
    send_req(32'h0000_0010, 1'b1, 32'haaaa_bbbb, 4'b0010);
    send_req(32'h0000_0010, 1'b0, 32'h0, 4'hf);
    send_req(32'h0000_0014, 1'b0, 32'h0, 4'hf);
    send_req(32'h0000_0030, 1'b0, 32'h0, 4'hf);
    send_req(32'h0000_1ff4, 1'b0, 32'h0, 4'hf);
    wait_drained("local responses");
    // Idle pipeline, so the read answers after exactly two edges
    send_req(32'h0000_0014, 1'b0, 32'h0, 4'hf);
    @(negedge clk_i);
    check_value(resp_valid_o, 1'b0, "resp_valid_o one cycle after a local read");
    @(negedge clk_i);
    check_value(resp_valid_o, 1'b0, "resp_valid_o two cycles after a local read");
    @(negedge clk_i);
    check_value(resp_valid_o, 1'b1, "resp_valid_o after the local read latency");
    wait_drained("the local read latency response");
  endtask

  task automatic test_remote();
    send_req(32'h0000_0104, 1'b0, 32'h0, 4'hf);
    send_req(32'h0000_0a08, 1'b1, 32'h0123_4567, 4'b0101);
    send_req(32'h0000_1f1c, 1'b1, 32'h89ab_cdef, 4'hf);
    send_req(32'h0000_1fe8, 1'b0, 32'h0, 4'hf);
    send_req(32'h0000_0a0b, 1'b1, 32'hfeed_face, 4'b1000);
    wait_drained("remote responses");
  endtask

  task automatic test_error();
    send_req(32'h0000_2000, 1'b0, 32'h0, 4'hf);
    // Aliases local word 0x10 if the region check were missing
    send_req(32'h0000_2010, 1'b1, 32'hbad0_bad0, 4'hf);
    send_req(32'hffff_fffc, 1'b0, 32'h0, 4'hf);
    send_req(32'h0001_0014, 1'b1, 32'hbad1_bad1, 4'hf);
    send_req(32'h0000_0010, 1'b0, 32'h0, 4'hf);
    send_req(32'h0000_0014, 1'b0, 32'h0, 4'hf);
    wait_drained("error region responses");
  endtask

  task automatic test_ordering();
    rmt_extra_delay = 4;
    send_req(32'h0000_0030, 1'b0, 32'h0, 4'hf);
    send_req(32'h0000_0104, 1'b0, 32'h0, 4'hf);
    send_req(32'h0000_3000, 1'b0, 32'h0, 4'hf);
    send_req(32'h0000_1ff4, 1'b0, 32'h0, 4'hf);
    send_req(32'h0000_0a08, 1'b1, 32'h1357_9bdf, 4'hf);
    send_req(32'h0000_0014, 1'b1, 32'h2468_ace0, 4'hf);
    send_req(32'h0000_2014, 1'b1, 32'h0bad_0bad, 4'hf);
    send_req(32'h0000_1f1c, 1'b0, 32'h0, 4'hf);
    send_req(32'h0000_0014, 1'b0, 32'h0, 4'hf);
    wait_drained("mixed route responses");
    rmt_extra_delay = 0;
  endtask

  task automatic test_back_pressure();
    logic [31:0] addr;
    int          accepted;
    bit          stalled;
    resp_ready_i = 1'b0;
    accepted = 0;
    stalled  = 1'b0;
    while (!stalled) begin
      case (accepted % 3)
        0:       addr = 32'h0000_0010;
        1:       addr = 32'h0000_0a08;
        default: addr = 32'h0000_2004;
      endcase
      req_valid_i = 1'b1;
      req_addr_i  = addr;
      req_wen_i   = 1'b0;
      req_wdata_i = 32'h0;
      req_be_i    = 4'hf;
      @(negedge clk_i);
      if (req_ready_o) begin
        @(posedge clk_i);
        #2;
        expect_resp(addr, 1'b0, 32'h0, 4'hf);
        accepted++;
        if (accepted > tile_cfg_pkg::QueueDepth + 1) begin
          $display("req_ready_o stayed high after %0d requests with responses stalled",
                   accepted);
          abort_run();
        end
      end else begin
        stalled = 1'b1;
      end
    end
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      check_value(req_ready_o, 1'b0, "req_ready_o while responses are stalled");
    end
    @(posedge clk_i);
    #2;
    resp_ready_i = 1'b1;
    wait_drained("responses after back-pressure");
  endtask

  // Core response checker
  always @(negedge clk_i) begin
    if (arst_n_i && resp_valid_o && resp_ready_i) begin
      if (exp_rdata.size() == 0) begin
        $display("Core response arrived with no request outstanding");
        abort_run();
      end else begin
        check_value(resp_rdata_o, exp_rdata[0], "core response data");
        check_value(resp_error_o, exp_error[0], "core response error flag");
        void'(exp_rdata.pop_front());
        void'(exp_error.pop_front());
      end
    end
  end

  // Remote side takes every request and checks it
  always @(negedge clk_i) begin
    if (arst_n_i && rmt_req_valid_o && rmt_req_ready_i) begin
      if (exp_rmt_addr.size() == 0) begin
        $display("Remote request left the tile with none expected");
        abort_run();
      end else begin
        check_value(rmt_req_addr_o, exp_rmt_addr[0], "remote request address");
        check_value(rmt_req_wen_o, exp_rmt_wen[0], "remote request write enable");
        if (exp_rmt_wen[0]) begin
          check_value(rmt_req_wdata_o, exp_rmt_wdata[0], "remote request write data");
          check_value(rmt_req_be_o, exp_rmt_be[0], "remote request byte enables");
        end
        void'(exp_rmt_addr.pop_front());
        void'(exp_rmt_wen.pop_front());
        void'(exp_rmt_wdata.pop_front());
        void'(exp_rmt_be.pop_front());
        rmt_pending.push_back(rmt_req_addr_o);
      end
    end
  end

  // Remote side answers in order after a random delay
  initial begin : remote_responder
    int delay;
    int cycles;
    void'($urandom(32'had566c81));
    rmt_resp_valid_i = 1'b0;
    rmt_resp_rdata_i = 32'h0;
    forever begin
      @(posedge clk_i);
      #2;
      if (rmt_pending.size() != 0) begin
        delay = $urandom_range(5) + rmt_extra_delay;
        if (delay != 0) begin
          repeat (delay) @(posedge clk_i);
          #2;
        end
        rmt_resp_valid_i = 1'b1;
        rmt_resp_rdata_i = rmt_pending[0] ^ RmtXor;
        cycles = 0;
        @(negedge clk_i);
        while (!rmt_resp_ready_o) begin
          cycles++;
          if (cycles > TimeoutCycles) begin
            timeout_abort("rmt_resp_ready_o");
          end
          @(negedge clk_i);
        end
        @(posedge clk_i);
        #2;
        rmt_resp_valid_i = 1'b0;
        void'(rmt_pending.pop_front());
      end
    end
  end

  initial begin
    error_count     = 0;
    rmt_extra_delay = 0;
    arst_n_i        = 1'b0;
    req_valid_i     = 1'b0;
    req_addr_i      = 32'h0;
    req_wen_i       = 1'b0;
    req_wdata_i     = 32'h0;
    req_be_i        = 4'h0;
    resp_ready_i    = 1'b1;
    rmt_req_ready_i = 1'b1;
    apply_reset();
    test_local();
    test_remote();
    test_error();
    test_ordering();
    test_back_pressure();
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
